// File: common/aluPkg.sv
package aluPkg;

    // Operand and result width
    localparam int dataWidth = 16;

    localparam int ctlWidth = 6;

    // Bit positions inside the control word
    localparam int ctlEx = 5;
    localparam int ctlNx = 4;
    localparam int ctlEy = 3;
    localparam int ctlNy = 2;
    localparam int ctlF  = 1;
    localparam int ctlNo = 0;

    // ex/ey pass the operand, nx/ny invert it,
    // f picks add over AND, no inverts the output
    typedef logic [ctlWidth-1:0] aluCtlT;

    // Carry is zero for AND, lessThan is the result sign bit
    typedef struct packed {
        logic carry;
        logic zero;
        logic lessThan;
    } flagsT;

endpackage

// File: common/isaPkg.sv
package isaPkg;

    import aluPkg::*;

    localparam int regCount = 8;
    localparam int regIndexWidth = $clog2(regCount);

    typedef logic [regIndexWidth-1:0] regIndexT;

    // One register-to-register instruction
    typedef struct packed {
        aluCtlT                 ctl;
        logic                   useCarry;
        // Immediate replaces source Y
        logic                   useImm;
        regIndexT               dest;
        regIndexT               srcX;
        regIndexT               srcY;
        logic [dataWidth-1:0]   imm;
    } instrT;

    // What leaves the unit for each instruction
    typedef struct packed {
        logic [dataWidth-1:0]   value;
        flagsT                  flags;
        regIndexT               dest;
    } resultT;

endpackage

// File: alu/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [aluPkg::dataWidth-1:0] x,
    input  logic [aluPkg::dataWidth-1:0] y,
    input  aluPkg::aluCtlT               ctl,
    input  logic                         carryIn,
    output logic [aluPkg::dataWidth-1:0] value,
    output aluPkg::flagsT                flags
);

    import aluPkg::*;

    logic [dataWidth-1:0] xZeroed;
    logic [dataWidth-1:0] yZeroed;
    logic [dataWidth-1:0] xOperand;
    logic [dataWidth-1:0] yOperand;
    logic [dataWidth:0]   sum;
    logic [dataWidth-1:0] andResult;
    logic [dataWidth-1:0] coreResult;
    logic                 coreCarry;

    // Operand conditioning
    always_comb begin
        xZeroed  = ctl[ctlEx] ? x : '0;
        yZeroed  = ctl[ctlEy] ? y : '0;
        xOperand = ctl[ctlNx] ? ~xZeroed : xZeroed;
        yOperand = ctl[ctlNy] ? ~yZeroed : yZeroed;
    end

    // Extra top bit catches the carry out
    assign sum = {1'b0, xOperand} + {1'b0, yOperand} + {{dataWidth{1'b0}}, carryIn};

    assign andResult = xOperand & yOperand;

    always_comb begin
        if (ctl[ctlF]) begin
            coreResult = sum[dataWidth-1:0];
            coreCarry  = sum[dataWidth];
        end else begin
            coreResult = andResult;
            coreCarry  = 1'b0;
        end
    end

    // Carry is taken before the output inversion
    assign value = ctl[ctlNo] ? ~coreResult : coreResult;

    always_comb begin
        flags.carry    = coreCarry;
        flags.zero     = (value == '0);
        flags.lessThan = value[dataWidth-1];
    end

endmodule

// File: verilog/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic                         clk,
    input  logic                         rstN,
    input  isaPkg::regIndexT             readIndexX,
    input  isaPkg::regIndexT             readIndexY,
    output logic [aluPkg::dataWidth-1:0] readDataX,
    output logic [aluPkg::dataWidth-1:0] readDataY,
    input  logic                         writeEnable,
    input  isaPkg::regIndexT             writeIndex,
    input  logic [aluPkg::dataWidth-1:0] writeData
);

    import aluPkg::*;
    import isaPkg::*;

    logic [dataWidth-1:0] regs [regCount];

    // Registers start at zero so the first reads are defined
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeIndex] <= writeData;
        end
    end

    // Reads see the value before this edge's write
    assign readDataX = regs[readIndexX];
    assign readDataY = regs[readIndexY];

endmodule

// File: verilog/handshakeStage.sv
`timescale 1ns/1ps

module handshakeStage #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    inValid,
    input  payloadT inData,
    output logic    inReady,
    output logic    outValid,
    output payloadT outData,
    input  logic    outReady
);

    logic accept;

    // Empty, or the held entry leaves this cycle
    assign inReady = !outValid || outReady;
    assign accept  = inValid && inReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    // Payload only moves on a transfer and holds under back-pressure
    always_ff @(posedge clk) begin
        if (accept) begin
            outData <= inData;
        end
    end

endmodule

// File: verilog/executeControl.sv
`timescale 1ns/1ps

module executeControl (
    input  logic                         clk,
    input  logic                         rstN,

    input  logic                         instrValid,
    input  isaPkg::instrT                instr,
    output logic                         instrReady,

    output isaPkg::regIndexT             regIndexX,
    output isaPkg::regIndexT             regIndexY,
    input  logic [aluPkg::dataWidth-1:0] regDataX,
    input  logic [aluPkg::dataWidth-1:0] regDataY,

    output logic [aluPkg::dataWidth-1:0] aluX,
    output logic [aluPkg::dataWidth-1:0] aluY,
    output aluPkg::aluCtlT               aluCtl,
    output logic                         aluCarryIn,
    input  logic [aluPkg::dataWidth-1:0] aluValue,
    input  aluPkg::flagsT                aluFlags,

    output logic                         regWriteEnable,
    output isaPkg::regIndexT             regWriteIndex,
    output logic [aluPkg::dataWidth-1:0] regWriteData,

    output logic                         resultValid,
    output isaPkg::resultT               result,
    input  logic                         resultReady
);

    import aluPkg::*;
    import isaPkg::*;

    flagsT flagReg;
    logic  fire;

    // Execute only when the output stage can take the result
    assign fire = instrValid && resultReady;

    // The input stage drains exactly when we execute
    assign instrReady = resultReady;

    // Register read
    assign regIndexX = instr.srcX;
    assign regIndexY = instr.srcY;

    // Operand select
    assign aluX = regDataX;
    assign aluY = instr.useImm ? instr.imm : regDataY;

    assign aluCtl = instr.ctl;

    // Stored carry chains multi-word adds
    assign aluCarryIn = instr.useCarry && flagReg.carry;

    // Writeback happens at the same edge the result is taken
    assign regWriteEnable = fire;
    assign regWriteIndex  = instr.dest;
    assign regWriteData   = aluValue;

    assign resultValid = instrValid;

    always_comb begin
        result.value = aluValue;
        result.flags = aluFlags;
        result.dest  = instr.dest;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            flagReg <= '0;
        end else if (fire) begin
            flagReg <= aluFlags;
        end
    end

endmodule

// File: verilog/executeUnit.sv
`timescale 1ns/1ps

module executeUnit (
    input  logic                         clk,
    input  logic                         rstN,

    input  logic                         instrValid,
    output logic                         instrReady,
    input  aluPkg::aluCtlT               ctl,
    input  logic                         useCarry,
    input  logic                         useImm,
    input  isaPkg::regIndexT             dest,
    input  isaPkg::regIndexT             srcX,
    input  isaPkg::regIndexT             srcY,
    input  logic [aluPkg::dataWidth-1:0] imm,

    output logic                         resultValid,
    input  logic                         resultReady,
    output logic [aluPkg::dataWidth-1:0] resultValue,
    output logic                         resultCarry,
    output logic                         resultZero,
    output logic                         resultLessThan,
    output isaPkg::regIndexT             resultDest
);

    import aluPkg::*;
    import isaPkg::*;

    instrT                instrIn;
    logic                 stagedValid;
    instrT                stagedInstr;
    logic                 stagedReady;

    regIndexT             regIndexX;
    regIndexT             regIndexY;
    logic [dataWidth-1:0] regDataX;
    logic [dataWidth-1:0] regDataY;
    logic                 regWriteEnable;
    regIndexT             regWriteIndex;
    logic [dataWidth-1:0] regWriteData;

    logic [dataWidth-1:0] aluX;
    logic [dataWidth-1:0] aluY;
    aluCtlT               aluCtl;
    logic                 aluCarryIn;
    logic [dataWidth-1:0] aluValue;
    flagsT                aluFlags;

    logic                 execValid;
    resultT               execResult;
    logic                 outStageReady;
    resultT               outResult;

    // Pack the loose instruction fields
    assign instrIn = '{ctl: ctl, useCarry: useCarry, useImm: useImm, dest: dest,
                       srcX: srcX, srcY: srcY, imm: imm};

    handshakeStage #(.payloadT(instrT)) inStage (
        .clk(clk), .rstN(rstN),
        .inValid(instrValid), .inData(instrIn), .inReady(instrReady),
        .outValid(stagedValid), .outData(stagedInstr), .outReady(stagedReady)
    );

    executeControl control (
        .clk(clk), .rstN(rstN),
        .instrValid(stagedValid), .instr(stagedInstr), .instrReady(stagedReady),
        .regIndexX(regIndexX), .regIndexY(regIndexY),
        .regDataX(regDataX), .regDataY(regDataY),
        .aluX(aluX), .aluY(aluY), .aluCtl(aluCtl), .aluCarryIn(aluCarryIn),
        .aluValue(aluValue), .aluFlags(aluFlags),
        .regWriteEnable(regWriteEnable), .regWriteIndex(regWriteIndex),
        .regWriteData(regWriteData),
        .resultValid(execValid), .result(execResult), .resultReady(outStageReady)
    );

    registerFile regFile (
        .clk(clk), .rstN(rstN),
        .readIndexX(regIndexX), .readIndexY(regIndexY),
        .readDataX(regDataX), .readDataY(regDataY),
        .writeEnable(regWriteEnable), .writeIndex(regWriteIndex),
        .writeData(regWriteData)
    );

    alu aluCore (
        .x(aluX), .y(aluY), .ctl(aluCtl), .carryIn(aluCarryIn),
        .value(aluValue), .flags(aluFlags)
    );

    handshakeStage #(.payloadT(resultT)) outStage (
        .clk(clk), .rstN(rstN),
        .inValid(execValid), .inData(execResult), .inReady(outStageReady),
        .outValid(resultValid), .outData(outResult), .outReady(resultReady)
    );

    // Unpack the result onto loose ports
    assign resultValue    = outResult.value;
    assign resultCarry    = outResult.flags.carry;
    assign resultZero     = outResult.flags.zero;
    assign resultLessThan = outResult.flags.lessThan;
    assign resultDest     = outResult.dest;

endmodule

// File: verification/executeUnit_properties.sv
`timescale 1ns/1ps

module executeUnitProperties (
    input logic                         clk,
    input logic                         rstN,
    input logic                         instrReady,
    input logic                         resultValid,
    input logic                         resultReady,
    input logic [aluPkg::dataWidth-1:0] resultValue,
    input isaPkg::regIndexT             resultDest,
    input logic                         resultCarry,
    input logic                         resultZero,
    input logic                         resultLessThan,
    input logic                         regWriteEnable
);

    // Held result stays put until taken
    property resultHeld;
        @(posedge clk) disable iff (!rstN)
            resultValid && !resultReady |=>
                resultValid && $stable(resultValue) && $stable(resultDest)
                && $stable(resultCarry) && $stable(resultZero)
                && $stable(resultLessThan);
    endproperty

    // First cycle out of reset is idle and open
    property resetState;
        @(posedge clk) $rose(rstN) |-> !resultValid && instrReady;
    endproperty

    // Writeback only when the output stage takes the result
    property writeOnTransfer;
        @(posedge clk) disable iff (!rstN)
            regWriteEnable |-> (!resultValid || resultReady) ##1 resultValid;
    endproperty

    assert property (resultHeld)
    else $error("result changed while stalled");

    assert property (resetState)
    else $error("wrong output state after reset");

    assert property (writeOnTransfer)
    else $error("register write without a result transfer");

endmodule

bind executeUnit executeUnitProperties props (
    .clk(clk), .rstN(rstN), .instrReady(instrReady),
    .resultValid(resultValid), .resultReady(resultReady),
    .resultValue(resultValue), .resultDest(resultDest), .resultCarry(resultCarry),
    .resultZero(resultZero), .resultLessThan(resultLessThan),
    .regWriteEnable(regWriteEnable)
);

// File: verification/executeUnitTb.sv
`timescale 1ns/1ps

module executeUnitTb;

    import aluPkg::*;
    import isaPkg::*;

    // Control words for the table functions
    localparam aluCtlT opAdd   = 6'b101010;
    localparam aluCtlT opSubXY = 6'b111011;
    localparam aluCtlT opSubYX = 6'b101111;
    localparam aluCtlT opAnd   = 6'b101000;
    localparam aluCtlT opOr    = 6'b111101;
    localparam aluCtlT opZero  = 6'b000010;
    localparam aluCtlT opOne   = 6'b010111;
    localparam aluCtlT opMinus = 6'b010010;
    localparam aluCtlT opX     = 6'b100100;
    localparam aluCtlT opY     = 6'b011000;
    localparam aluCtlT opNotX  = 6'b100101;
    localparam aluCtlT opNotY  = 6'b011001;
    localparam aluCtlT opNegX  = 6'b100111;
    localparam aluCtlT opNegY  = 6'b011011;
    localparam aluCtlT opIncX  = 6'b110111;
    localparam aluCtlT opIncY  = 6'b011111;
    localparam aluCtlT opDecX  = 6'b100110;
    localparam aluCtlT opDecY  = 6'b011010;

    logic clk;
    logic rstN;
    logic instrValid;
    logic instrReady;
    aluCtlT ctl;
    logic useCarry;
    logic useImm;
    regIndexT dest;
    regIndexT srcX;
    regIndexT srcY;
    logic [dataWidth-1:0] imm;
    logic resultValid;
    logic resultReady;
    logic [dataWidth-1:0] resultValue;
    logic resultCarry;
    logic resultZero;
    logic resultLessThan;
    regIndexT resultDest;

    // Stimulus table with expected results
    instrT tblInstr[$];
    logic [dataWidth-1:0] tblValue[$];
    flagsT tblFlags[$];

    logic [dataWidth-1:0] modelRegs [regCount];
    logic modelCarry;
    aluCtlT funcList [18];
    int checkIdx;
    int cycles;
    int cycleLimit;
    bit stallMode;

    executeUnit DUT (
        .clk(clk), .rstN(rstN),
        .instrValid(instrValid), .instrReady(instrReady),
        .ctl(ctl), .useCarry(useCarry), .useImm(useImm),
        .dest(dest), .srcX(srcX), .srcY(srcY), .imm(imm),
        .resultValid(resultValid), .resultReady(resultReady),
        .resultValue(resultValue), .resultCarry(resultCarry), .resultZero(resultZero),
        .resultLessThan(resultLessThan), .resultDest(resultDest)
    );

    always #5 clk = ~clk;

    task automatic reportFailure(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // Predicts one instruction from the ALU rules and updates the model state
    task automatic addEntry(input aluCtlT c, input logic uc, input logic ui,
                            input regIndexT d, input regIndexT sx, input regIndexT sy,
                            input logic [dataWidth-1:0] im);
        instrT in;
        logic [dataWidth-1:0] x;
        logic [dataWidth-1:0] y;
        logic [dataWidth:0] wide;
        logic [dataWidth-1:0] r;
        logic cOut;
        flagsT fl;
        in = '{ctl: c, useCarry: uc, useImm: ui, dest: d, srcX: sx, srcY: sy, imm: im};
        x = c[ctlEx] ? modelRegs[sx] : '0;
        y = ui ? im : modelRegs[sy];
        y = c[ctlEy] ? y : '0;
        if (c[ctlNx]) x = ~x;
        if (c[ctlNy]) y = ~y;
        if (c[ctlF]) begin
            wide = x + y + (uc & modelCarry);
            r = wide[dataWidth-1:0];
            cOut = wide[dataWidth];
        end else begin
            r = x & y;
            cOut = 1'b0;
        end
        if (c[ctlNo]) r = ~r;
        fl.carry = cOut;
        fl.zero = (r == 0);
        fl.lessThan = r[dataWidth-1];
        modelRegs[d] = r;
        modelCarry = cOut;
        tblInstr.push_back(in);
        tblValue.push_back(r);
        tblFlags.push_back(fl);
    endtask

    // Sends table entries, holding each until it is taken
    task automatic sendRange(input int first, input int last, input bit gaps);
        int idx;
        idx = first;
        while (idx <= last) begin
            if (gaps && ($urandom % 4 == 0)) begin
                instrValid <= 1'b0;
                @(posedge clk);
            end else begin
                instrValid <= 1'b1;
                ctl <= tblInstr[idx].ctl;
                useCarry <= tblInstr[idx].useCarry;
                useImm <= tblInstr[idx].useImm;
                dest <= tblInstr[idx].dest;
                srcX <= tblInstr[idx].srcX;
                srcY <= tblInstr[idx].srcY;
                imm <= tblInstr[idx].imm;
                @(posedge clk);
                while (!instrReady) @(posedge clk);
                idx++;
            end
        end
        instrValid <= 1'b0;
    endtask

    // Result monitor and output back-pressure
    always @(posedge clk) begin
        resultReady <= stallMode ? ($urandom % 3 != 0) : 1'b1;
        if (rstN && resultValid && resultReady) begin
            assert (checkIdx < tblValue.size())
            else reportFailure("result with no instruction outstanding");
            assert (resultValue == tblValue[checkIdx])
            else reportFailure($sformatf("entry %0d value %h expected %h",
                               checkIdx, resultValue, tblValue[checkIdx]));
            assert (resultCarry == tblFlags[checkIdx].carry)
            else reportFailure($sformatf("entry %0d carry flag", checkIdx));
            assert (resultZero == tblFlags[checkIdx].zero)
            else reportFailure($sformatf("entry %0d zero flag", checkIdx));
            assert (resultLessThan == tblFlags[checkIdx].lessThan)
            else reportFailure($sformatf("entry %0d lessThan flag", checkIdx));
            assert (resultDest == tblInstr[checkIdx].dest)
            else reportFailure($sformatf("entry %0d dest", checkIdx));
            checkIdx++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("Timeout: results did not arrive within %0d cycles", cycleLimit);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

    initial begin
        int tableEnd;
        int randomEnd;
        logic [dataWidth-1:0] loads [8];
        regIndexT prev;
        void'($urandom(22575));
        clk = 0;
        rstN = 0;
        instrValid = 0;
        ctl = '0;
        useCarry = 0;
        useImm = 0;
        dest = '0;
        srcX = '0;
        srcY = '0;
        imm = '0;
        resultReady = 0;
        stallMode = 0;
        checkIdx = 0;
        cycles = 0;
        cycleLimit = 0;
        modelCarry = 0;
        for (int i = 0; i < regCount; i++) modelRegs[i] = '0;
        funcList = '{opAdd, opSubXY, opSubYX, opAnd, opOr, opZero, opOne, opMinus, opX,
                     opY, opNotX, opNotY, opNegX, opNegY, opIncX, opIncY, opDecX, opDecY};
        loads = '{16'h0005, 16'h0003, 16'h8000, 16'h7fff,
                  16'h00f0, 16'h0f0f, 16'hffff, 16'h1234};

        // Immediate loads and read back
        for (int i = 0; i < 8; i++) addEntry(opY, 0, 1, i, 0, 0, loads[i]);
        for (int i = 0; i < 8; i++) addEntry(opX, 0, 0, i, i, 0, 16'h0);
        // All functions on two operand pairs
        for (int i = 0; i < 18; i++) addEntry(funcList[i], 0, 0, 6, 0, 1, 16'h0);
        for (int i = 0; i < 18; i++) addEntry(funcList[i], 0, 0, 7, 2, 4, 16'h0);
        // Carry chain, then the same add after a carry-clear result
        addEntry(opY, 0, 1, 5, 0, 0, 16'hffff);
        addEntry(opAdd, 0, 1, 5, 5, 0, 16'hffff);
        addEntry(opAdd, 1, 1, 3, 0, 0, 16'h0010);
        addEntry(opAnd, 0, 1, 4, 5, 0, 16'h00ff);
        addEntry(opAdd, 1, 1, 3, 0, 0, 16'h0010);
        tableEnd = tblInstr.size() - 1;
        for (int i = 0; i < 200; i++) begin
            addEntry($urandom % 64, $urandom % 2, $urandom % 2, $urandom % 8,
                     $urandom % 8, $urandom % 8, $urandom);
        end
        randomEnd = tblInstr.size() - 1;
        // Each instruction reads the previous destination
        prev = 0;
        for (int i = 0; i < 24; i++) begin
            addEntry(funcList[$urandom % 18], 0, 1, (i * 3) % 8, prev, 0, $urandom);
            prev = (i * 3) % 8;
        end
        cycleLimit = 20 * tblInstr.size() + 100;

        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);
        sendRange(0, tableEnd, 0);
        stallMode = 1;
        sendRange(tableEnd + 1, randomEnd, 1);
        stallMode = 0;
        sendRange(randomEnd + 1, tblInstr.size() - 1, 0);
        while (checkIdx < tblInstr.size()) @(posedge clk);
        repeat (5) @(posedge clk);
        if (checkIdx == tblInstr.size()) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("Extra results arrived after the last instruction");
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

endmodule

// File: sources.f
common/aluPkg.sv
common/isaPkg.sv
alu/alu.sv
verilog/registerFile.sv
verilog/handshakeStage.sv
verilog/executeControl.sv
verilog/executeUnit.sv
verification/executeUnit_properties.sv
verification/executeUnitTb.sv
